// File: vlog.f
logic/blur_pkg.sv
logic/ctrl_pkg.sv
logic/blur_win_if.sv
logic/strip_ctrl.sv
logic/line_window.sv
logic/blur_kernel_3x3.sv
logic/gauss_blur_top.sv
tb/tb_gauss_blur.sv

// File: Makefile
# Verilator flow for the Gaussian blur engine

TOP := tb_gauss_blur

.PHONY: all lint sim clean

all: sim

lint:
	verilator --lint-only -Wall -Wno-fatal --timing -f vlog.f --top-module gauss_blur_top

sim:
	verilator --binary --timing --assert -Wno-fatal -f vlog.f --top-module $(TOP) -Mdir obj_dir
	./obj_dir/V$(TOP) | tee sim.log
	grep -q "sim passed" sim.log

clean:
	rm -rf obj_dir sim.log

// File: tb/tb_gauss_blur.sv
`timescale 1ns/1ps
`default_nettype none

module tb_gauss_blur;

  localparam int IMG_W = 64;
  localparam int IMG_H = 12;
  localparam int OUT_CREDITS = 3;
  localparam int NUM_STRIPS = IMG_W / blur_pkg::LANES;
  localparam int RUN_OUTPUTS = IMG_H * NUM_STRIPS;
  localparam int STALL_CYCLES = 40;
  localparam int RUN_TIMEOUT = 3000;

  logic                             clk = 1'b0;
  logic                             rst_n;
  logic                             start;
  logic                             done;
  logic                             img_rd;
  logic [ctrl_pkg::ROW_W-1:0]       img_addr;
  logic [IMG_W*blur_pkg::PIX_W-1:0] img_data = '0;
  logic                             out_valid;
  logic [ctrl_pkg::ROW_W-1:0]       out_row;
  logic [ctrl_pkg::STRIP_W-1:0]     out_strip;
  blur_pkg::strip_t                 out_data;
  logic                             out_credit = 1'b0;

  integer seed = 51;
  logic [7:0] image [IMG_H][IMG_W];

  // scoreboard with one slot per run
  int  run_idx = 0;
  int  run_base = 0;
  bit  seen [2][IMG_H][NUM_STRIPS];
  int  next_row [2][NUM_STRIPS];
  int  outputs_total = 0;
  int  stall_outputs = 0;
  int  credits_sent = 0;
  bit  hold_credits = 1'b0;
  bit  stall_window = 1'b0;

  int data_errs = 0;
  int order_errs = 0;
  int credit_errs = 0;
  int ctrl_errs = 0;
  int timeouts = 0;

  always #10 clk = ~clk;

  gauss_blur_top #(
    .IMG_W       (IMG_W),
    .IMG_H       (IMG_H),
    .OUT_CREDITS (OUT_CREDITS)
  ) i_dut (
    .clk        (clk),
    .rst_n      (rst_n),
    .start      (start),
    .done       (done),
    .img_rd     (img_rd),
    .img_addr   (img_addr),
    .img_data   (img_data),
    .out_valid  (out_valid),
    .out_row    (out_row),
    .out_strip  (out_strip),
    .out_data   (out_data),
    .out_credit (out_credit)
  );

  function automatic int pixel_at(int r, int x);
    if ((r < 0) || (r >= IMG_H) || (x < 0) || (x >= IMG_W))
      return 0;
    return int'(image[r][x]);
  endfunction

  // weight is the product of the 1-2-1 taps in each direction
  function automatic blur_pkg::strip_t expected_strip(int r, int s);
    blur_pkg::strip_t res;
    int sum;
    int x;
    int wy;
    int wx;
    res = '0;
    for (int lane = 0; lane < blur_pkg::LANES; lane++) begin
      x = s * blur_pkg::LANES + lane;
      sum = 0;
      for (int dy = -1; dy <= 1; dy++) begin
        for (int dx = -1; dx <= 1; dx++) begin
          wy = (dy == 0) ? 2 : 1;
          wx = (dx == 0) ? 2 : 1;
          sum += wy * wx * pixel_at(r + dy, x + dx);
        end
      end
      res[lane*8 +: 8] = 8'((sum + 8) / 16);
    end
    return res;
  endfunction

  function automatic logic [IMG_W*blur_pkg::PIX_W-1:0] row_word(int r);
    logic [IMG_W*blur_pkg::PIX_W-1:0] w;
    w = '0;
    if (r < IMG_H) begin
      for (int x = 0; x < IMG_W; x++)
        w[x*8 +: 8] = image[r][x];
    end
    return w;
  endfunction

  task automatic fill_image();
    for (int r = 0; r < IMG_H; r++) begin
      for (int x = 0; x < IMG_W; x++)
        image[r][x] = 8'($random(seed));
    end
  endtask

  task automatic check_output();
    blur_pkg::strip_t exp;
    int r;
    int s;
    r = int'(out_row);
    s = int'(out_strip);
    assert ((r < IMG_H) && (s < NUM_STRIPS)) else begin
      order_errs++;
      $display("ERR out_row 0x%h out_strip 0x%h outside the image", out_row, out_strip);
    end
    if ((r < IMG_H) && (s < NUM_STRIPS)) begin
      assert (!seen[run_idx][r][s]) else begin
        order_errs++;
        $display("row %0d of strip %0d was delivered twice", r, s);
      end
      assert (r >= next_row[run_idx][s]) else begin
        order_errs++;
        $display("ERR out_row: expected at least 0x%h, got 0x%h", next_row[run_idx][s], r);
      end
      seen[run_idx][r][s] = 1'b1;
      next_row[run_idx][s] = r + 1;
      exp = expected_strip(r, s);
      assert (out_data === exp) else begin
        data_errs++;
        $display("ERR out_data row %0d strip %0d: expected 0x%h, got 0x%h", r, s, exp, out_data);
      end
    end
  endtask

  task automatic check_all_seen();
    for (int r = 0; r < IMG_H; r++) begin
      for (int s = 0; s < NUM_STRIPS; s++) begin
        assert (seen[run_idx][r][s]) else begin
          order_errs++;
          $display("row %0d of strip %0d never arrived", r, s);
        end
      end
    end
  endtask

  task automatic finish_run();
    $display("outputs %0d, data errors %0d, order errors %0d, credit errors %0d, %s %0d, %s %0d",
             outputs_total, data_errs, order_errs, credit_errs, "control errors", ctrl_errs,
             "timeouts", timeouts);
    if ((data_errs + order_errs + credit_errs + ctrl_errs + timeouts) == 0)
      $display("sim passed");
    else
      $display("sim failed");
    $finish;
  endtask

  task automatic report_timeout(input string what);
    timeouts++;
    $display("timeout while waiting for %s", what);
  endtask

  // memory model and credit sink sample outputs mid-cycle
  always begin : bus_model
    int cycle;
    int credit_due [$];
    logic rd_seen;
    logic [ctrl_pkg::ROW_W-1:0] addr_seen;
    @(negedge clk);
    cycle++;
    rd_seen = img_rd;
    addr_seen = img_addr;
    if (rst_n && out_valid) begin
      outputs_total++;
      if (stall_window)
        stall_outputs++;
      check_output();
      credit_due.push_back(cycle + ($random(seed) & 7));
    end
    if (rst_n) begin
      assert (outputs_total <= OUT_CREDITS + credits_sent) else begin
        credit_errs++;
        $display("ERR out_valid count 0x%h exceeds credits granted 0x%h",
                 outputs_total, OUT_CREDITS + credits_sent);
      end
      if (!start) begin
        assert (!done || (outputs_total - run_base >= RUN_OUTPUTS)) else begin
          ctrl_errs++;
          $display("ERR done: expected 0x0, got 0x%h", done);
        end
      end
    end
    @(posedge clk);
    #1;
    if (rd_seen === 1'b1)
      img_data = row_word(int'(addr_seen));
    if (!hold_credits && (credit_due.size() > 0) && (credit_due[0] <= cycle)) begin
      void'(credit_due.pop_front());
      credits_sent++;
      out_credit = 1'b1;
    end else begin
      out_credit = 1'b0;
    end
  end

  task automatic run_sweep(input bit with_stall);
    int waited;
    @(posedge clk);
    #1;
    run_base = outputs_total;
    start = 1'b1;
    hold_credits = with_stall;
    stall_window = with_stall;
    @(posedge clk);
    #1;
    start = 1'b0;
    assert (done === 1'b0) else begin
      ctrl_errs++;
      $display("ERR done after start: expected 0x0, got 0x%h", done);
    end
    if (with_stall) begin
      repeat (STALL_CYCLES - 1) @(posedge clk);
      #1;
      hold_credits = 1'b0;
      stall_window = 1'b0;
      assert (stall_outputs <= OUT_CREDITS) else begin
        credit_errs++;
        $display("ERR outputs during stall: expected at most 0x%h, got 0x%h",
                 OUT_CREDITS, stall_outputs);
      end
    end
    waited = 0;
    while ((outputs_total - run_base < RUN_OUTPUTS) && (waited < RUN_TIMEOUT)) begin
      @(posedge clk);
      waited++;
    end
    #1;
    if (outputs_total - run_base < RUN_OUTPUTS) begin
      report_timeout("all blurred rows of the sweep");
      return;
    end
    waited = 0;
    while ((done !== 1'b1) && (waited < 8)) begin
      @(negedge clk);
      waited++;
    end
    if (done !== 1'b1) begin
      report_timeout("done after the last blurred row");
      return;
    end
    check_all_seen();
    // done must hold while idle
    repeat (20) begin
      @(negedge clk);
      assert (done === 1'b1) else begin
        ctrl_errs++;
        $display("ERR done while idle: expected 0x1, got 0x%h", done);
      end
    end
  endtask

  initial begin
    rst_n = 1'b0;
    start = 1'b0;
    fill_image();
    repeat (16) @(posedge clk);
    #1;
    rst_n = 1'b1;
    @(negedge clk);
    assert ((img_rd === 1'b0) && (out_valid === 1'b0) && (done === 1'b0)) else begin
      ctrl_errs++;
      $display("ERR after reset: img_rd 0x%h out_valid 0x%h done 0x%h, expected 0x0",
               img_rd, out_valid, done);
    end
    run_sweep(1'b1);
    if (timeouts == 0) begin
      // second sweep on a fresh image
      fill_image();
      run_idx = 1;
      run_sweep(1'b0);
    end
    finish_run();
  end

endmodule

`default_nettype wire

// File: logic/gauss_blur_top.sv
`timescale 1ns/1ps
`default_nettype none

module gauss_blur_top #(
  parameter int IMG_W       = 64,
  parameter int IMG_H       = 12,
  parameter int OUT_CREDITS = 3
) (
  input  logic                             clk,
  input  logic                             rst_n,
  input  logic                             start,
  output logic                             done,

  // image memory, img_data returns one cycle after img_rd
  output logic                             img_rd,
  output logic [ctrl_pkg::ROW_W-1:0]       img_addr,
  input  logic [IMG_W*blur_pkg::PIX_W-1:0] img_data,

  // blurred strip segments
  output logic                             out_valid,
  output logic [ctrl_pkg::ROW_W-1:0]       out_row,
  output logic [ctrl_pkg::STRIP_W-1:0]     out_strip,
  output blur_pkg::strip_t                 out_data,

  // one pulse per returned credit
  input  logic                             out_credit
);

  logic                         row_valid;
  logic                         row_zero;
  logic [ctrl_pkg::STRIP_W-1:0] strip_idx;
  logic [ctrl_pkg::ROW_W-1:0]   out_row_idx;

  blur_win_if win_bus ();

  strip_ctrl #(
    .IMG_W       (IMG_W),
    .IMG_H       (IMG_H),
    .OUT_CREDITS (OUT_CREDITS)
  ) i_ctrl (
    .clk         (clk),
    .rst_n       (rst_n),
    .start       (start),
    .out_credit  (out_credit),
    .img_rd      (img_rd),
    .img_addr    (img_addr),
    .row_valid   (row_valid),
    .row_zero    (row_zero),
    .strip_idx   (strip_idx),
    .out_row_idx (out_row_idx),
    .done        (done)
  );

  line_window #(
    .IMG_W (IMG_W)
  ) i_window (
    .clk         (clk),
    .rst_n       (rst_n),
    .row_valid   (row_valid),
    .row_zero    (row_zero),
    .strip_idx   (strip_idx),
    .out_row_idx (out_row_idx),
    .img_data    (img_data),
    .win         (win_bus.src)
  );

  blur_kernel_3x3 i_kernel (
    .clk       (clk),
    .rst_n     (rst_n),
    .win       (win_bus.dst),
    .out_valid (out_valid),
    .out_row   (out_row),
    .out_strip (out_strip),
    .out_data  (out_data)
  );

endmodule

`default_nettype wire

// File: logic/blur_kernel_3x3.sv
`timescale 1ns/1ps
`default_nettype none

module blur_kernel_3x3 (
  input  logic                         clk,
  input  logic                         rst_n,
  blur_win_if.dst                      win,
  output logic                         out_valid,
  output logic [ctrl_pkg::ROW_W-1:0]   out_row,
  output logic [ctrl_pkg::STRIP_W-1:0] out_strip,
  output blur_pkg::strip_t             out_data
);

  // 1-2-1 row sum needs two extra bits, full kernel four
  localparam int ROW_SUM_W = blur_pkg::PIX_W + 2;
  localparam int SUM_W = blur_pkg::PIX_W + 4;

  // horizontal 1-2-1 around segment pixel c
  function automatic logic [ROW_SUM_W-1:0] row_121(input blur_pkg::seg_t seg, input int c);
    logic [ROW_SUM_W-1:0] left;
    logic [ROW_SUM_W-1:0] centre;
    logic [ROW_SUM_W-1:0] right;
    left = ROW_SUM_W'(seg[(c-1)*blur_pkg::PIX_W +: blur_pkg::PIX_W]);
    centre = ROW_SUM_W'(seg[c*blur_pkg::PIX_W +: blur_pkg::PIX_W]);
    right = ROW_SUM_W'(seg[(c+1)*blur_pkg::PIX_W +: blur_pkg::PIX_W]);
    return left + (centre << 1) + right;
  endfunction

  blur_pkg::strip_t blur_res;

  for (genvar i = 0; i < blur_pkg::LANES; i++) begin : g_lane
    logic [ROW_SUM_W-1:0] top_sum;
    logic [ROW_SUM_W-1:0] mid_sum;
    logic [ROW_SUM_W-1:0] bot_sum;
    logic [SUM_W-1:0]     total;

    // lane i is centred on segment pixel i+1
    assign top_sum = row_121(win.top, i + blur_pkg::HALO);
    assign mid_sum = row_121(win.mid, i + blur_pkg::HALO);
    assign bot_sum = row_121(win.bot, i + blur_pkg::HALO);

    // vertical 1-2-1 plus rounding
    assign total = SUM_W'(top_sum) + (SUM_W'(mid_sum) << 1) + SUM_W'(bot_sum) +
                   SUM_W'(blur_pkg::ROUND_ADD);

    assign blur_res[i*blur_pkg::PIX_W +: blur_pkg::PIX_W] =
      blur_pkg::pixel_t'(total >> blur_pkg::KERNEL_SHIFT);
  end

  always_ff @(posedge clk) begin
    if (!rst_n)
      out_valid <= 1'b0;
    else
      out_valid <= win.win_valid;
  end

  // result and position travel together
  always_ff @(posedge clk) begin
    if (win.win_valid) begin
      out_data  <= blur_res;
      out_row   <= win.row;
      out_strip <= win.strip;
    end
  end

endmodule

`default_nettype wire

// File: logic/line_window.sv
`timescale 1ns/1ps
`default_nettype none

module line_window #(
  parameter int IMG_W = 64
) (
  input  logic                              clk,
  input  logic                              rst_n,
  input  logic                              row_valid,
  input  logic                              row_zero,
  input  logic [ctrl_pkg::STRIP_W-1:0]      strip_idx,
  input  logic [ctrl_pkg::ROW_W-1:0]        out_row_idx,
  input  logic [IMG_W*blur_pkg::PIX_W-1:0]  img_data,
  blur_win_if.src                           win
);

  blur_pkg::seg_t seg_in;
  blur_pkg::seg_t top_q;
  blur_pkg::seg_t mid_q;
  blur_pkg::seg_t bot_q;

  logic [ctrl_pkg::ROW_W-1:0]   row_q;
  logic [ctrl_pkg::STRIP_W-1:0] strip_q;
  logic                         valid_q;

  // set once a strip has its first row in the window
  logic primed;

  // strip plus halo, pixel 0 of img_data is the left image edge
  always_comb begin
    int px;
    seg_in = '0;
    for (int j = 0; j < blur_pkg::SEG_PIX; j++) begin
      px = int'(strip_idx) * blur_pkg::LANES + j - blur_pkg::HALO;
      // left and right image edges pad with zero
      if (!row_zero && (px >= 0) && (px < IMG_W))
        seg_in[j*blur_pkg::PIX_W +: blur_pkg::PIX_W] =
          img_data[px*blur_pkg::PIX_W +: blur_pkg::PIX_W];
    end
  end

  always_ff @(posedge clk) begin
    if (row_valid) begin
      if (!primed) begin
        // top padding, row -1 is all zero
        top_q <= '0;
        mid_q <= '0;
      end else begin
        top_q <= mid_q;
        mid_q <= bot_q;
      end
      bot_q   <= seg_in;
      row_q   <= out_row_idx;
      strip_q <= strip_idx;
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      primed  <= 1'b0;
      valid_q <= 1'b0;
    end else begin
      // priming row gives no output
      valid_q <= row_valid && primed;
      // flush row closes the strip
      if (row_valid)
        primed <= !row_zero;
    end
  end

  assign win.win_valid = valid_q;
  assign win.top = top_q;
  assign win.mid = mid_q;
  assign win.bot = bot_q;
  assign win.row = row_q;
  assign win.strip = strip_q;

endmodule

`default_nettype wire

// File: logic/strip_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

module strip_ctrl #(
  parameter int IMG_W       = 64,
  parameter int IMG_H       = 12,
  parameter int OUT_CREDITS = 3
) (
  input  logic                         clk,
  input  logic                         rst_n,
  input  logic                         start,
  input  logic                         out_credit,
  output logic                         img_rd,
  output logic [ctrl_pkg::ROW_W-1:0]   img_addr,
  output logic                         row_valid,
  output logic                         row_zero,
  output logic [ctrl_pkg::STRIP_W-1:0] strip_idx,
  output logic [ctrl_pkg::ROW_W-1:0]   out_row_idx,
  output logic                         done
);

  localparam int NUM_STRIPS = IMG_W / blur_pkg::LANES;
  localparam int CRED_W = $clog2(OUT_CREDITS + 1);
  localparam int DRAIN_W = $clog2(ctrl_pkg::PIPE_DEPTH + 1);
  localparam logic [ctrl_pkg::ROW_W-1:0] LAST_ROW = ctrl_pkg::ROW_W'(IMG_H - 1);
  localparam logic [ctrl_pkg::STRIP_W-1:0] LAST_STRIP = ctrl_pkg::STRIP_W'(NUM_STRIPS - 1);

  ctrl_pkg::sweep_state_e state;
  ctrl_pkg::sweep_state_e state_nxt;

  // row_cnt is the next image row to read
  logic [ctrl_pkg::ROW_W-1:0]   row_cnt;
  logic [ctrl_pkg::STRIP_W-1:0] strip_cnt;
  logic [CRED_W-1:0]            credit_cnt;
  logic [DRAIN_W-1:0]           drain_cnt;

  logic has_credit;
  logic step_rd;
  logic step_flush;
  logic spend;

  assign has_credit = (credit_cnt != '0);

  // first row of a strip only primes the window, so it is free
  assign step_rd = (state == ctrl_pkg::ST_FIRST_ROW) ||
                   ((state == ctrl_pkg::ST_NEXT_ROW) && has_credit);
  assign step_flush = (state == ctrl_pkg::ST_FLUSH) && has_credit;

  // every step that completes an output row costs one credit
  assign spend = ((state == ctrl_pkg::ST_NEXT_ROW) || (state == ctrl_pkg::ST_FLUSH)) &&
                 has_credit;

  assign img_rd = step_rd;
  assign img_addr = row_cnt;

  always_comb begin
    state_nxt = state;
    case (state)
      ctrl_pkg::ST_IDLE: begin
        if (start)
          state_nxt = ctrl_pkg::ST_FIRST_ROW;
      end
      ctrl_pkg::ST_FIRST_ROW: begin
        state_nxt = (LAST_ROW == '0) ? ctrl_pkg::ST_FLUSH : ctrl_pkg::ST_NEXT_ROW;
      end
      ctrl_pkg::ST_NEXT_ROW: begin
        if (has_credit && (row_cnt == LAST_ROW))
          state_nxt = ctrl_pkg::ST_FLUSH;
      end
      ctrl_pkg::ST_FLUSH: begin
        if (has_credit)
          state_nxt = ctrl_pkg::ST_NEXT_STRIP;
      end
      ctrl_pkg::ST_NEXT_STRIP: begin
        state_nxt = (strip_cnt == LAST_STRIP) ? ctrl_pkg::ST_DRAIN : ctrl_pkg::ST_FIRST_ROW;
      end
      ctrl_pkg::ST_DRAIN: begin
        if (drain_cnt == '0)
          state_nxt = ctrl_pkg::ST_IDLE;
      end
      default: begin
        state_nxt = ctrl_pkg::ST_IDLE;
      end
    endcase
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      state      <= ctrl_pkg::ST_IDLE;
      row_cnt    <= '0;
      strip_cnt  <= '0;
      credit_cnt <= CRED_W'(OUT_CREDITS);
      drain_cnt  <= '0;
      row_valid  <= 1'b0;
      done       <= 1'b0;
    end else begin
      state <= state_nxt;
      // return and spend in the same cycle cancel out
      credit_cnt <= credit_cnt + CRED_W'(out_credit) - CRED_W'(spend);
      // one cycle later, lined up with img_data
      row_valid <= step_rd || step_flush;

      if ((state == ctrl_pkg::ST_IDLE) && start) begin
        row_cnt   <= '0;
        strip_cnt <= '0;
        done      <= 1'b0;
      end

      if (step_rd)
        row_cnt <= row_cnt + 1'b1;

      if (state == ctrl_pkg::ST_NEXT_STRIP) begin
        row_cnt   <= '0;
        drain_cnt <= DRAIN_W'(ctrl_pkg::PIPE_DEPTH - 1);
        if (strip_cnt != LAST_STRIP)
          strip_cnt <= strip_cnt + 1'b1;
      end

      // wait for the last flush to reach out_valid
      if (state == ctrl_pkg::ST_DRAIN) begin
        if (drain_cnt == '0)
          done <= 1'b1;
        else
          drain_cnt <= drain_cnt - 1'b1;
      end
    end
  end

  // step tags, read row minus one is the row being completed
  always_ff @(posedge clk) begin
    row_zero    <= step_flush;
    strip_idx   <= strip_cnt;
    out_row_idx <= row_cnt - 1'b1;
  end

endmodule

`default_nettype wire

// File: logic/blur_win_if.sv
`timescale 1ns/1ps
`default_nettype none

// three-row window plus the output position it belongs to
interface blur_win_if;

  logic win_valid;

  // rows r-1, r and r+1 of the current strip
  blur_pkg::seg_t top;
  blur_pkg::seg_t mid;
  blur_pkg::seg_t bot;

  // output row and strip for this window
  logic [ctrl_pkg::ROW_W-1:0] row;
  logic [ctrl_pkg::STRIP_W-1:0] strip;

  modport src (
    output win_valid,
    output top,
    output mid,
    output bot,
    output row,
    output strip
  );

  modport dst (
    input win_valid,
    input top,
    input mid,
    input bot,
    input row,
    input strip
  );

endinterface

`default_nettype wire

// File: logic/ctrl_pkg.sv
`default_nettype none

package ctrl_pkg;

  // sweep FSM states
  typedef enum logic [2:0] {
    ST_IDLE       = 3'd0,
    ST_FIRST_ROW  = 3'd1,
    ST_NEXT_ROW   = 3'd2,
    ST_FLUSH      = 3'd3,
    ST_NEXT_STRIP = 3'd4,
    ST_DRAIN      = 3'd5
  } sweep_state_e;

  // index widths
  localparam int ROW_W = 10;
  localparam int STRIP_W = 6;

  // window register plus kernel output register
  localparam int PIPE_DEPTH = 2;

endpackage

`default_nettype wire

// File: logic/blur_pkg.sv
`default_nettype none

package blur_pkg;

  // pixel format
  localparam int PIX_W = 8;

  // strip geometry, one lane per output pixel
  localparam int LANES = 16;
  localparam int HALO = 1;
  localparam int SEG_PIX = LANES + 2 * HALO;

  typedef logic [PIX_W-1:0] pixel_t;

  // lane 0 sits in the low bits
  typedef logic [LANES*PIX_W-1:0] strip_t;

  // window row, pixel 0 is the left halo
  typedef logic [SEG_PIX*PIX_W-1:0] seg_t;

  // 1-2-1 / 2-4-2 / 1-2-1 weights sum to 16
  localparam int KERNEL_SHIFT = 4;

  // half of the divisor, round to nearest
  localparam int ROUND_ADD = 8;

endpackage

`default_nettype wire
